/* rtl/dot_pkg.sv */
package dot_pkg;

    // ============================================================
    // Datapath widths
    // ============================================================

    // One operand of a dot-product lane
    localparam int OP_W = 16;

    // Full unsigned product of two operands
    localparam int PROD_W = 2 * OP_W;

    // Sum of two products, one carry bit
    localparam int SUM_W = PROD_W + 1;

    // Sum of four products, two carry bits in total
    localparam int RES_W = PROD_W + 2;

    // ============================================================
    // Structure and latency
    // ============================================================

    // Operand pairs per operation
    localparam int LANES = 4;

    // Multiplier pipeline depth, input register not included
    localparam int MULT_LAT = 2;

endpackage

/* rtl/dot_ctrl.sv */
`timescale 1ns/100ps

module dot_ctrl #(
    parameter int DEPTH = 64,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic              CLK,
    input  logic              RST_N,
    input  logic              en_mac,
    input  logic              en_block_read,
    input  logic              res_valid,
    output logic              rdy_mac,
    output logic              rdy_block_read,
    output logic              accept,
    output logic              wr_en,
    output logic              rd_en,
    output logic [ADDR_W-1:0] wr_addr,
    output logic [ADDR_W-1:0] rd_addr
);

    // State encoding
    localparam logic [1:0] IDLE    = 2'd0;
    localparam logic [1:0] WRITING = 2'd1;
    localparam logic [1:0] FULL    = 2'd2;
    localparam logic [1:0] READING = 2'd3;

    logic [1:0]        state;
    logic [1:0]        state_nxt;
    // One extra bit, the MSB flags DEPTH accepts in this round
    logic [ADDR_W:0]   issue_cnt;
    logic [ADDR_W-1:0] wr_cnt;
    logic [ADDR_W-1:0] rd_cnt;
    logic              blk_accept;
    logic              wr_last;
    logic              rd_last;

    // ============================================================
    // Handshakes
    // ============================================================

    // Take new work until DEPTH operations are in flight or stored
    assign rdy_mac = ((state == IDLE) || (state == WRITING)) && !issue_cnt[ADDR_W];
    assign accept  = en_mac && rdy_mac;

    // Block read only offered with a full buffer
    assign rdy_block_read = (state == FULL);
    assign blk_accept     = en_block_read && rdy_block_read;

    // Results land the cycle they leave the adder tree
    assign wr_en   = res_valid && (state == WRITING);
    assign wr_addr = wr_cnt;

    // One read per cycle for the whole READING state
    assign rd_en   = (state == READING);
    assign rd_addr = rd_cnt;

    // Last address is all ones, DEPTH is a power of two
    assign wr_last = wr_en && (&wr_cnt);
    assign rd_last = rd_en && (&rd_cnt);

    // ============================================================
    // FSM
    // ============================================================

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (accept)     state_nxt = WRITING;
            WRITING: if (wr_last)    state_nxt = FULL;
            FULL:    if (blk_accept) state_nxt = READING;
            READING: if (rd_last)    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state     <= IDLE;
            issue_cnt <= '0;
            wr_cnt    <= '0;
            rd_cnt    <= '0;
        end else begin
            state <= state_nxt;
            // Issue count restarts once the round has been read out
            if (rd_last) begin
                issue_cnt <= '0;
            end else if (accept) begin
                issue_cnt <= issue_cnt + 1'b1;
            end
            // Both address counters wrap back to 0 at the end of a pass
            if (wr_en) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (rd_en) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

endmodule

/* rtl/mult_lanes.sv */
`timescale 1ns/100ps

module mult_lanes import dot_pkg::*; (
    input  logic              CLK,
    input  logic              RST_N,
    input  logic              accept,
    input  logic [OP_W-1:0]   vect_a0,
    input  logic [OP_W-1:0]   vect_a1,
    input  logic [OP_W-1:0]   vect_a2,
    input  logic [OP_W-1:0]   vect_a3,
    input  logic [OP_W-1:0]   vect_b0,
    input  logic [OP_W-1:0]   vect_b1,
    input  logic [OP_W-1:0]   vect_b2,
    input  logic [OP_W-1:0]   vect_b3,
    output logic              prod_valid,
    output logic [PROD_W-1:0] prod0,
    output logic [PROD_W-1:0] prod1,
    output logic [PROD_W-1:0] prod2,
    output logic [PROD_W-1:0] prod3
);

    // B is split in halves, each half gives one partial product
    localparam int HALF_W = OP_W / 2;
    localparam int PP_W   = OP_W + HALF_W;

    logic [OP_W-1:0]   a_in   [LANES];
    logic [OP_W-1:0]   b_in   [LANES];
    logic [OP_W-1:0]   a_r    [LANES];
    logic [OP_W-1:0]   b_r    [LANES];
    logic [PP_W-1:0]   pp_lo  [LANES];
    logic [PP_W-1:0]   pp_hi  [LANES];
    logic [PROD_W-1:0] prod_r [LANES];
    logic              in_valid;
    logic              pp_valid;

    // Gather loose operand ports into lane arrays
    assign a_in[0] = vect_a0;
    assign a_in[1] = vect_a1;
    assign a_in[2] = vect_a2;
    assign a_in[3] = vect_a3;
    assign b_in[0] = vect_b0;
    assign b_in[1] = vect_b1;
    assign b_in[2] = vect_b2;
    assign b_in[3] = vect_b3;

    // ============================================================
    // Valid pipe, input register then two multiply stages
    // ============================================================

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            in_valid   <= 1'b0;
            pp_valid   <= 1'b0;
            prod_valid <= 1'b0;
        end else begin
            in_valid   <= accept;
            pp_valid   <= in_valid;
            prod_valid <= pp_valid;
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < LANES; i++) begin
            // Operands only need to be valid in the accept cycle
            if (accept) begin
                a_r[i] <= a_in[i];
                b_r[i] <= b_in[i];
            end
            // Stage 1: A times low and high byte of B
            pp_lo[i] <= a_r[i] * b_r[i][HALF_W-1:0];
            pp_hi[i] <= a_r[i] * b_r[i][OP_W-1:HALF_W];
            // Stage 2: shift and merge into the full product
            prod_r[i] <= (PROD_W'(pp_hi[i]) << HALF_W) + PROD_W'(pp_lo[i]);
        end
    end

    assign prod0 = prod_r[0];
    assign prod1 = prod_r[1];
    assign prod2 = prod_r[2];
    assign prod3 = prod_r[3];

endmodule

/* rtl/adder_tree.sv */
`timescale 1ns/100ps

module adder_tree import dot_pkg::*; (
    input  logic              CLK,
    input  logic              RST_N,
    input  logic              prod_valid,
    input  logic [PROD_W-1:0] prod0,
    input  logic [PROD_W-1:0] prod1,
    input  logic [PROD_W-1:0] prod2,
    input  logic [PROD_W-1:0] prod3,
    output logic              res_valid,
    output logic [RES_W-1:0]  res_data
);

    logic [PROD_W-1:0] cap0;
    logic [PROD_W-1:0] cap1;
    logic [PROD_W-1:0] cap2;
    logic [PROD_W-1:0] cap3;
    logic [SUM_W-1:0]  sum01;
    logic [SUM_W-1:0]  sum23;
    logic [SUM_W-1:0]  sum01_r;
    logic [SUM_W-1:0]  sum23_r;
    logic              cap_valid;
    logic              sum_valid;
    logic              sum_r_valid;

    // ============================================================
    // Valid chain, one flop per tree stage
    // ============================================================

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            cap_valid   <= 1'b0;
            sum_valid   <= 1'b0;
            sum_r_valid <= 1'b0;
            res_valid   <= 1'b0;
        end else begin
            cap_valid   <= prod_valid;
            sum_valid   <= cap_valid;
            sum_r_valid <= sum_valid;
            res_valid   <= sum_r_valid;
        end
    end

    always_ff @(posedge CLK) begin
        // Capture the four products of one operation together
        if (prod_valid) begin
            cap0 <= prod0;
            cap1 <= prod1;
            cap2 <= prod2;
            cap3 <= prod3;
        end
        // Pairwise sums keep their carry
        sum01   <= SUM_W'(cap0) + SUM_W'(cap1);
        sum23   <= SUM_W'(cap2) + SUM_W'(cap3);
        // Extra register to split the adder path
        sum01_r <= sum01;
        sum23_r <= sum23;
        // Final sum, 4 x ffff x ffff still fits
        res_data <= RES_W'(sum01_r) + RES_W'(sum23_r);
    end

endmodule

/* rtl/result_buffer.sv */
`timescale 1ns/100ps

module result_buffer import dot_pkg::*; #(
    parameter int DEPTH = 64,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic              CLK,
    input  logic              RST_N,
    input  logic              wr_en,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [ADDR_W-1:0] rd_addr,
    input  logic [RES_W-1:0]  res_data,
    output logic              mem_valid,
    output logic [RES_W-1:0]  mem_data
);

    logic [RES_W-1:0] mem [DEPTH];
    logic [RES_W-1:0] rd_word;
    logic             rd_valid;

    // ============================================================
    // Storage, synchronous read and output register
    // ============================================================

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_addr] <= res_data;
        end
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
        mem_data <= rd_word;
    end

    // Valid follows the data two cycles behind rd_en
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            rd_valid  <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            rd_valid  <= rd_en;
            mem_valid <= rd_valid;
        end
    end

endmodule

/* rtl/dot_top.sv */
`timescale 1ns/100ps

module dot_top import dot_pkg::*; #(
    parameter int DEPTH = 64,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic             CLK,
    input  logic             RST_N,
    input  logic             en_mac,
    input  logic [OP_W-1:0]  vect_a0,
    input  logic [OP_W-1:0]  vect_a1,
    input  logic [OP_W-1:0]  vect_a2,
    input  logic [OP_W-1:0]  vect_a3,
    input  logic [OP_W-1:0]  vect_b0,
    input  logic [OP_W-1:0]  vect_b1,
    input  logic [OP_W-1:0]  vect_b2,
    input  logic [OP_W-1:0]  vect_b3,
    output logic             rdy_mac,
    input  logic             en_block_read,
    output logic             rdy_block_read,
    output logic             mem_valid,
    output logic [RES_W-1:0] mem_data
);

    logic              accept;
    logic              prod_valid;
    logic [PROD_W-1:0] prod0;
    logic [PROD_W-1:0] prod1;
    logic [PROD_W-1:0] prod2;
    logic [PROD_W-1:0] prod3;
    logic              res_valid;
    logic [RES_W-1:0]  res_data;
    logic              wr_en;
    logic              rd_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    // Control, handshakes and buffer addressing
    dot_ctrl #(.DEPTH(DEPTH)) ctrl_inst (
        .CLK(CLK), .RST_N(RST_N), .en_mac(en_mac), .en_block_read(en_block_read),
        .res_valid(res_valid), .rdy_mac(rdy_mac), .rdy_block_read(rdy_block_read),
        .accept(accept), .wr_en(wr_en), .rd_en(rd_en), .wr_addr(wr_addr), .rd_addr(rd_addr)
    );

    // Input register and four multipliers, 3 cycles
    mult_lanes mult_inst (
        .CLK(CLK), .RST_N(RST_N), .accept(accept),
        .vect_a0(vect_a0), .vect_a1(vect_a1), .vect_a2(vect_a2), .vect_a3(vect_a3),
        .vect_b0(vect_b0), .vect_b1(vect_b1), .vect_b2(vect_b2), .vect_b3(vect_b3),
        .prod_valid(prod_valid), .prod0(prod0), .prod1(prod1), .prod2(prod2), .prod3(prod3)
    );

    // Reduction of four products, 4 cycles
    adder_tree tree_inst (
        .CLK(CLK), .RST_N(RST_N), .prod_valid(prod_valid),
        .prod0(prod0), .prod1(prod1), .prod2(prod2), .prod3(prod3),
        .res_valid(res_valid), .res_data(res_data)
    );

    // Result storage and read stream
    result_buffer #(.DEPTH(DEPTH)) buf_inst (
        .CLK(CLK), .RST_N(RST_N), .wr_en(wr_en), .rd_en(rd_en),
        .wr_addr(wr_addr), .rd_addr(rd_addr), .res_data(res_data),
        .mem_valid(mem_valid), .mem_data(mem_data)
    );

endmodule

/* verification/dot_props.sv */
`timescale 1ns/100ps

module dot_props #(
    parameter int DEPTH = 64
) (
    input logic CLK,
    input logic RST_N,
    input logic rdy_mac,
    input logic rdy_block_read,
    input logic accept,
    input logic wr_en,
    input logic rd_en
);

    // Length of the current run of rd_en cycles
    int rd_run;
    // Accepts since the last read burst
    int acc_cnt;
    // Number of failed assertions so far
    int fail_cnt = 0;

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            rd_run <= 0;
        end else if (rd_en) begin
            rd_run <= rd_run + 1;
        end else begin
            rd_run <= 0;
        end
    end

    // A read burst closes the round of accepts
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            acc_cnt <= 0;
        end else if (rd_en) begin
            acc_cnt <= 0;
        end else if (accept) begin
            acc_cnt <= acc_cnt + 1;
        end
    end

    // ============================================================
    // Controller properties
    // ============================================================

    // Operation and block-read handshakes never offered together
    ready_exclusive: assert property (@(posedge CLK) disable iff (!RST_N)
        !(rdy_mac && rdy_block_read))
        else begin
            fail_cnt++;
            $error("rdy_mac and rdy_block_read both high");
        end

    // Buffer port used by one side at a time
    port_exclusive: assert property (@(posedge CLK) disable iff (!RST_N)
        !(wr_en && rd_en))
        else begin
            fail_cnt++;
            $error("wr_en and rd_en both high");
        end

    // Work only taken while ready and at most DEPTH times per round
    accept_needs_ready: assert property (@(posedge CLK) disable iff (!RST_N)
        accept |-> (rdy_mac && (acc_cnt < DEPTH)))
        else begin
            fail_cnt++;
            $error("accept without rdy_mac or beyond DEPTH in one round");
        end

    // A read burst never exceeds DEPTH cycles
    burst_not_long: assert property (@(posedge CLK) disable iff (!RST_N)
        rd_en |-> (rd_run < DEPTH))
        else begin
            fail_cnt++;
            $error("read burst longer than DEPTH");
        end

    // A read burst that ends has lasted exactly DEPTH cycles
    burst_full_length: assert property (@(posedge CLK) disable iff (!RST_N)
        (!rd_en && (rd_run != 0)) |-> (rd_run == DEPTH))
        else begin
            fail_cnt++;
            $error("read burst shorter than DEPTH");
        end

endmodule

/* verification/dot_tb.sv */
`timescale 1ns/100ps

module dot_tb import dot_pkg::*; ();

    localparam int DEPTH          = 64;
    localparam int COLS           = 2 * LANES + 1;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = 2 * (DEPTH * 4 + 20) + RESET_CYCLES;
    localparam string GOLDEN_FILE = "verification/dot_golden.txt";

    logic             CLK;
    logic             RST_N;
    logic             en_mac;
    logic [OP_W-1:0]  vect_a0;
    logic [OP_W-1:0]  vect_a1;
    logic [OP_W-1:0]  vect_a2;
    logic [OP_W-1:0]  vect_a3;
    logic [OP_W-1:0]  vect_b0;
    logic [OP_W-1:0]  vect_b1;
    logic [OP_W-1:0]  vect_b2;
    logic [OP_W-1:0]  vect_b3;
    logic             rdy_mac;
    logic             en_block_read;
    logic             rdy_block_read;
    logic             mem_valid;
    logic [RES_W-1:0] mem_data;

    // Flat copy of the golden file with COLS words per vector
    logic [RES_W-1:0] golden [DEPTH * COLS];
    logic [31:0]      rand_state = 32'h02b5_12fa;
    int               cycle_cnt  = 0;

    dot_top #(.DEPTH(DEPTH)) dot_top_inst (
        .CLK(CLK), .RST_N(RST_N), .en_mac(en_mac),
        .vect_a0(vect_a0), .vect_a1(vect_a1), .vect_a2(vect_a2), .vect_a3(vect_a3),
        .vect_b0(vect_b0), .vect_b1(vect_b1), .vect_b2(vect_b2), .vect_b3(vect_b3),
        .rdy_mac(rdy_mac), .en_block_read(en_block_read), .rdy_block_read(rdy_block_read),
        .mem_valid(mem_valid), .mem_data(mem_data)
    );

    // Controller assertions
    bind dot_ctrl dot_props #(.DEPTH(DEPTH)) props_inst (
        .CLK(CLK), .RST_N(RST_N), .rdy_mac(rdy_mac), .rdy_block_read(rdy_block_read),
        .accept(accept), .wr_en(wr_en), .rd_en(rd_en)
    );

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    // Run limit of two rounds plus reset
    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "run stopped by timeout");
        end
    end

    // ============================================================
    // Helpers
    // ============================================================

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_result(input logic [RES_W-1:0] got, input logic [RES_W-1:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("error at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s, got %b, expected %b", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "flag mismatch");
        end
    endtask

    // Golden operands of one vector onto the ports
    task automatic drive_vector(input int idx);
        int base;
        base    = idx * COLS;
        en_mac  = 1'b1;
        vect_a0 = golden[base][OP_W-1:0];
        vect_a1 = golden[base + 1][OP_W-1:0];
        vect_a2 = golden[base + 2][OP_W-1:0];
        vect_a3 = golden[base + 3][OP_W-1:0];
        vect_b0 = golden[base + 4][OP_W-1:0];
        vect_b1 = golden[base + 5][OP_W-1:0];
        vect_b2 = golden[base + 6][OP_W-1:0];
        vect_b3 = golden[base + 7][OP_W-1:0];
    endtask

    // Random operands that must never reach the buffer
    task automatic drive_junk(input logic en);
        rand_state = next_rand(rand_state);
        en_mac  = en;
        vect_a0 = rand_state[15:0];
        vect_a1 = rand_state[31:16];
        vect_a2 = ~rand_state[15:0];
        vect_a3 = ~rand_state[31:16];
        vect_b0 = rand_state[23:8];
        vect_b1 = ~rand_state[23:8];
        vect_b2 = 16'hffff;
        vect_b3 = rand_state[15:0] ^ rand_state[31:16];
    endtask

    // One round of DEPTH operations with optional idle gaps
    task automatic fill_round(input bit gaps);
        for (int i = 0; i < DEPTH; i++) begin
            if (gaps) begin
                rand_state = next_rand(rand_state);
                if (rand_state[31]) begin
                    drive_junk(1'b0);
                    check_flag(mem_valid, 1'b0, "mem_valid in fill gap");
                    @(negedge CLK);
                end
            end
            drive_vector(i);
            check_flag(rdy_mac, 1'b1, "rdy_mac while filling");
            check_flag(rdy_block_read, 1'b0, "rdy_block_read while filling");
            check_flag(mem_valid, 1'b0, "mem_valid while filling");
            @(negedge CLK);
        end
    endtask

    // Called with the block read request pending on the next edge
    task automatic read_block();
        @(negedge CLK);
        en_block_read = 1'b0;
        while (!mem_valid) begin
            @(negedge CLK);
        end
        for (int i = 0; i < DEPTH; i++) begin
            check_flag(mem_valid, 1'b1, "mem_valid inside read stream");
            check_result(mem_data, golden[i * COLS + 2 * LANES],
                         $sformatf("mem_data of entry %0d", i));
            @(negedge CLK);
        end
        check_flag(mem_valid, 1'b0, "mem_valid after read stream");
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        $readmemh(GOLDEN_FILE, golden);
        RST_N         = 1'b0;
        en_block_read = 1'b0;
        drive_junk(1'b0);
        repeat (RESET_CYCLES) @(negedge CLK);
        RST_N = 1'b1;
        @(negedge CLK);
        check_flag(rdy_mac, 1'b1, "rdy_mac after reset");
        check_flag(rdy_block_read, 1'b0, "rdy_block_read after reset");
        check_flag(mem_valid, 1'b0, "mem_valid after reset");

        // Round 1 with the block read requested the whole time
        en_block_read = 1'b1;
        fill_round(1'b0);
        en_mac = 1'b0;
        check_flag(rdy_mac, 1'b0, "rdy_mac after DEPTH accepts");
        while (!rdy_block_read) begin
            check_flag(mem_valid, 1'b0, "mem_valid before buffer full");
            check_flag(rdy_mac, 1'b0, "rdy_mac while draining pipeline");
            @(negedge CLK);
        end
        read_block();
        check_flag(rdy_mac, 1'b1, "rdy_mac after first read");

        // Round 2 with random gaps and en_mac held while not ready
        fill_round(1'b1);
        while (!rdy_block_read) begin
            drive_junk(1'b1);
            check_flag(rdy_mac, 1'b0, "rdy_mac after second fill");
            @(negedge CLK);
        end
        repeat (3) begin
            drive_junk(1'b1);
            check_flag(rdy_mac, 1'b0, "rdy_mac in FULL");
            check_flag(rdy_block_read, 1'b1, "rdy_block_read in FULL");
            @(negedge CLK);
        end
        en_mac        = 1'b0;
        en_block_read = 1'b1;
        read_block();
        check_flag(rdy_mac, 1'b1, "rdy_mac after second read");

        if (dot_top_inst.ctrl_inst.props_inst.fail_cnt == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "controller assertions failed");
        end
    end

endmodule

/* verification/dot_golden.txt */
// Columns: a0 a1 a2 a3 b0 b1 b2 b3 expected, all hex, expected is the 34-bit dot product
// One vector per line, results are read back from the engine in this order
0000 0000 0000 0000 0000 0000 0000 0000 000000000
ffff ffff ffff ffff ffff ffff ffff ffff 3fff80004
ffff 0000 0000 0000 ffff 0000 0000 0000 0fffe0001
ffff ffff ffff ffff 0002 0003 0004 0005 0000dfff2
ffff ffff ffff ffff 8000 8000 8000 8000 1fffe0000
ffff ffff ffff ffff 00ff 00ff 00ff 00ff 003fbfc04
ffff ffff ffff ffff ff00 ff00 ff00 ff00 3fbfc0400
00ff 00ff 00ff 00ff 00ff 00ff 00ff 00ff 00003f804
1234 5678 9abc def0 0100 0100 0100 0100 001e25800
1234 5678 9abc def0 0010 0010 0010 0010 0001e2580
1234 5678 9abc def0 1000 1000 1000 1000 01e258000
aaaa aaaa aaaa aaaa 0003 0003 0003 0003 00007fff8
5555 5555 5555 5555 0003 0003 0003 0003 00003fffc
8000 8000 8000 8000 8000 8000 8000 8000 100000000
0001 0002 0004 0008 0010 0020 0040 0080 000000550
ffff 0000 ffff 0000 0001 ffff ffff 0001 0ffff0000
0001 0001 0001 0001 0001 0002 0003 0004 00000000a
0002 0002 0002 0002 0001 0002 0003 0004 000000014
0003 0003 0003 0003 0001 0002 0003 0004 00000001e
0004 0004 0004 0004 0001 0002 0003 0004 000000028
0005 0005 0005 0005 0001 0002 0003 0004 000000032
0006 0006 0006 0006 0001 0002 0003 0004 00000003c
0007 0007 0007 0007 0001 0002 0003 0004 000000046
0008 0008 0008 0008 0001 0002 0003 0004 000000050
0009 0009 0009 0009 0001 0002 0003 0004 00000005a
000a 000a 000a 000a 0001 0002 0003 0004 000000064
000b 000b 000b 000b 0001 0002 0003 0004 00000006e
000c 000c 000c 000c 0001 0002 0003 0004 000000078
000d 000d 000d 000d 0001 0002 0003 0004 000000082
000e 000e 000e 000e 0001 0002 0003 0004 00000008c
000f 000f 000f 000f 0001 0002 0003 0004 000000096
0010 0010 0010 0010 0001 0002 0003 0004 0000000a0
ffff ffff ffff ffff 0001 0000 0000 0000 00000ffff
ffff ffff ffff ffff 0000 0002 0000 0000 00001fffe
ffff ffff ffff ffff 0000 0000 0004 0000 00003fffc
ffff ffff ffff ffff 0000 0000 0000 0008 00007fff8
ffff ffff ffff ffff 0010 0000 0000 0000 0000ffff0
ffff ffff ffff ffff 0000 0020 0000 0000 0001fffe0
ffff ffff ffff ffff 0000 0000 0040 0000 0003fffc0
ffff ffff ffff ffff 0000 0000 0000 0080 0007fff80
ffff ffff ffff ffff 0100 0000 0000 0000 000ffff00
ffff ffff ffff ffff 0000 0200 0000 0000 001fffe00
ffff ffff ffff ffff 0000 0000 0400 0000 003fffc00
ffff ffff ffff ffff 0000 0000 0000 0800 007fff800
ffff ffff ffff ffff 1000 0000 0000 0000 00ffff000
ffff ffff ffff ffff 0000 2000 0000 0000 01fffe000
ffff ffff ffff ffff 0000 0000 4000 0000 03fffc000
ffff ffff ffff ffff 0000 0000 0000 8000 07fff8000
0001 0001 0001 0001 ffff ffff ffff ffff 00003fffc
0002 0002 0002 0002 ffff ffff ffff ffff 00007fff8
0004 0004 0004 0004 ffff ffff ffff ffff 0000ffff0
0008 0008 0008 0008 ffff ffff ffff ffff 0001fffe0
0010 0010 0010 0010 ffff ffff ffff ffff 0003fffc0
0020 0020 0020 0020 ffff ffff ffff ffff 0007fff80
0040 0040 0040 0040 ffff ffff ffff ffff 000ffff00
0080 0080 0080 0080 ffff ffff ffff ffff 001fffe00
0100 0100 0100 0100 ffff ffff ffff ffff 003fffc00
0200 0200 0200 0200 ffff ffff ffff ffff 007fff800
0400 0400 0400 0400 ffff ffff ffff ffff 00ffff000
0800 0800 0800 0800 ffff ffff ffff ffff 01fffe000
1000 1000 1000 1000 ffff ffff ffff ffff 03fffc000
2000 2000 2000 2000 ffff ffff ffff ffff 07fff8000
4000 4000 4000 4000 ffff ffff ffff ffff 0ffff0000
8000 8000 8000 8000 ffff ffff ffff ffff 1fffe0000

/* project.f */
rtl/dot_pkg.sv
rtl/dot_ctrl.sv
rtl/mult_lanes.sv
rtl/adder_tree.sv
rtl/result_buffer.sv
rtl/dot_top.sv
verification/dot_props.sv
verification/dot_tb.sv

/* Makefile */
# Verilator flow for the dot-product engine

VERILATOR ?= verilator
TOP       ?= dot_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --timing --assert -sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

# Pass only when the log holds the pass line
sim: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
